// ==== Makefile ====
# Verilator build and run of the register file and address translation testbench

VERILATOR ?= verilator
TOP       ?= agc_reg_addr_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Overridable variables:"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) LOG=$(LOG) VFLAGS='$(VFLAGS)'"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) || { echo "FAIL: see $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
src/agc_pkg.sv
src/fixed_addr_map.sv
src/erasable_addr_map.sv
src/addr_translate.sv
src/central_regs.sv
src/agc_reg_addr_top.sv
verification/agc_reg_addr_tb.sv

// ==== src/addr_translate.sv ====
// Fetch, data-read and data-write address translation with erasable write gating
`timescale 1ns/1ns

module addr_translate (
  input  agc_pkg::soft_addr_t addr_pc,
  input  agc_pkg::soft_addr_t addr_r,
  input  agc_pkg::soft_addr_t addr_w,
  input  agc_pkg::bank_bits_t banks,
  input  logic                mem_write_en,
  output agc_pkg::rom_addr_t  rom_addr_pc,
  output agc_pkg::rom_addr_t  rom_addr_r,
  output agc_pkg::ram_addr_t  ram_addr_r,
  output agc_pkg::ram_addr_t  ram_addr_w,
  output logic                ram_write_en
);

  import agc_pkg::*;

  // Raw translations on the read side
  rom_addr_t rom_r_fixed;
  ram_addr_t ram_r_erasable;

  logic r_is_erasable;
  logic w_is_erasable;

  // Instruction fetch is always from ROM
  fixed_addr_map i_fixed_pc (
    .addr     (addr_pc),
    .fb       (banks.fb),
    .rom_addr (rom_addr_pc)
  );

  fixed_addr_map i_fixed_r (
    .addr     (addr_r),
    .fb       (banks.fb),
    .rom_addr (rom_r_fixed)
  );

  erasable_addr_map i_erasable_r (
    .addr     (addr_r),
    .eb       (banks.eb),
    .ram_addr (ram_r_erasable)
  );

  erasable_addr_map i_erasable_w (
    .addr     (addr_w),
    .eb       (banks.eb),
    .ram_addr (ram_addr_w)
  );

  assign r_is_erasable = (addr_r < ERASABLE_TOP);
  assign w_is_erasable = (addr_w < ERASABLE_TOP);

  // Unused side parks on its idle address
  assign rom_addr_r = r_is_erasable ? ROM_IDLE_ADDR : rom_r_fixed;
  assign ram_addr_r = r_is_erasable ? ram_r_erasable : '0;

  // Writes into fixed memory are dropped
  assign ram_write_en = mem_write_en & w_is_erasable;

endmodule

// ==== src/agc_pkg.sv ====
// Word, address and selector types, port structs and memory-map constants
package agc_pkg;

  // Machine word and address widths
  typedef logic [14:0] word_t;
  typedef logic [11:0] soft_addr_t;
  typedef logic [13:0] rom_addr_t;
  typedef logic [10:0] ram_addr_t;

  // One bank field, EB or FB
  typedef logic [2:0] bank_t;

  // Central register selector
  typedef enum logic [3:0] {
    A     = 4'd0,
    L     = 4'd1,
    Q     = 4'd2,
    EB    = 4'd3,
    FB    = 4'd4,
    BB    = 4'd5,
    ZERO  = 4'd6,
    CYR   = 4'd7,
    SR    = 4'd8,
    CYL   = 4'd9,
    SL    = 4'd10,
    TIME1 = 4'd11,
    TIME2 = 4'd12
  } reg_sel_t;

  // One register file write port
  typedef struct packed {
    logic     en;
    reg_sel_t sel;
    word_t    data;
  } reg_write_t;

  // Current erasable and fixed banks
  typedef struct packed {
    bank_t eb;
    bank_t fb;
  } bank_bits_t;

  // Erasable below this, fixed at or above
  localparam soft_addr_t ERASABLE_TOP = 12'o2000;

  // Start of the banked erasable window
  localparam soft_addr_t ERASABLE_BANKED_BASE = 12'o1400;

  // Start of fixed-fixed memory
  localparam soft_addr_t FIXED_FIXED_BASE = 12'o4000;

  // Bank sizes in ROM and RAM words
  localparam rom_addr_t FIXED_BANK_SIZE = 14'o2000;
  localparam ram_addr_t ERASABLE_BANK_SIZE = 11'o0400;

  // ROM address parked on while the read side targets erasable
  localparam rom_addr_t ROM_IDLE_ADDR = 14'o2000;

endpackage

// ==== src/agc_reg_addr_top.sv ====
// Top level joining the central register file and the address translation
`timescale 1ns/1ns

module agc_reg_addr_top (
  input  logic                clk,
  input  logic                rst_l,
  input  agc_pkg::reg_write_t wr1,
  input  agc_pkg::reg_write_t wr2,
  input  agc_pkg::reg_sel_t   rs1_sel,
  input  agc_pkg::reg_sel_t   rs2_sel,
  input  agc_pkg::soft_addr_t addr_pc,
  input  agc_pkg::soft_addr_t addr_r,
  input  agc_pkg::soft_addr_t addr_w,
  input  logic                mem_write_en,
  output agc_pkg::word_t      rs1_data,
  output agc_pkg::word_t      rs2_data,
  output agc_pkg::rom_addr_t  rom_addr_pc,
  output agc_pkg::rom_addr_t  rom_addr_r,
  output agc_pkg::ram_addr_t  ram_addr_r,
  output agc_pkg::ram_addr_t  ram_addr_w,
  output logic                ram_write_en
);

  import agc_pkg::*;

  // Stored banks, one cycle behind a bank write
  bank_bits_t banks;

  central_regs i_central_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1      (wr1),
    .wr2      (wr2),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .banks    (banks)
  );

  addr_translate i_addr_translate (
    .addr_pc      (addr_pc),
    .addr_r       (addr_r),
    .addr_w       (addr_w),
    .banks        (banks),
    .mem_write_en (mem_write_en),
    .rom_addr_pc  (rom_addr_pc),
    .rom_addr_r   (rom_addr_r),
    .ram_addr_r   (ram_addr_r),
    .ram_addr_w   (ram_addr_w),
    .ram_write_en (ram_write_en)
  );

endmodule

// ==== src/central_regs.sv ====
// Central register file with two write ports, forwarding reads and bank-bit taps
`timescale 1ns/1ns

module central_regs (
  input  logic                clk,
  input  logic                rst_l,
  input  agc_pkg::reg_write_t wr1,
  input  agc_pkg::reg_write_t wr2,
  input  agc_pkg::reg_sel_t   rs1_sel,
  input  agc_pkg::reg_sel_t   rs2_sel,
  output agc_pkg::word_t      rs1_data,
  output agc_pkg::word_t      rs2_data,
  output agc_pkg::bank_bits_t banks
);

  import agc_pkg::*;

  // Accumulators and link
  word_t reg_a;
  word_t reg_l;
  word_t reg_q;

  // Editing registers hold the already shifted word
  word_t reg_cyr;
  word_t reg_sr;
  word_t reg_cyl;
  word_t reg_sl;

  // Timers
  word_t reg_time1;
  word_t reg_time2;

  // Shared EB/FB storage
  bank_bits_t bank_q;

  // Bank field after port 1, and after both ports
  bank_bits_t bank_mid;
  bank_bits_t bank_next;

  // Value each port would leave behind
  word_t wr1_val;
  word_t wr2_val;

  // Value every selector holds after the coming edge
  word_t [15:0] nxt;

  // Word stored by one write. Bank selectors return the merged
  // bank word {fb, eb} at bits 14:9, other field from cur
  function automatic word_t stored_value(reg_write_t wr, bank_bits_t cur);
    word_t      d;
    bank_bits_t b;
    d = wr.data;
    b = cur;
    case (wr.sel)
      CYR: d = {wr.data[0], wr.data[14:1]};
      SR:  d = {wr.data[14], wr.data[14:1]};
      CYL: d = {wr.data[13:0], wr.data[14]};
      SL:  d = {wr.data[13:0], 1'b0};
      EB: begin
        b.eb = wr.data[11:9];
        d = {b.fb, b.eb, 9'd0};
      end
      FB: begin
        b.fb = wr.data[14:12];
        d = {b.fb, b.eb, 9'd0};
      end
      BB: begin
        b.fb = wr.data[14:12];
        b.eb = wr.data[11:9];
        d = {b.fb, b.eb, 9'd0};
      end
      ZERO: d = '0;
      // A, L, Q and the timers store the word as is
      default: d = wr.data;
    endcase
    return d;
  endfunction

  assign wr1_val = stored_value(wr1, bank_q);
  assign wr2_val = stored_value(wr2, bank_mid);

  // Port 1 then port 2 on the bank field, so port 2 wins per field
  always_comb begin
    bank_mid = bank_q;
    if (wr1.en && (wr1.sel inside {EB, FB, BB})) begin
      bank_mid.eb = wr1_val[11:9];
      bank_mid.fb = wr1_val[14:12];
    end
  end

  always_comb begin
    bank_next = bank_mid;
    if (wr2.en && (wr2.sel inside {EB, FB, BB})) begin
      bank_next.eb = wr2_val[11:9];
      bank_next.fb = wr2_val[14:12];
    end
  end

  // Next-state view that forwarding also reads
  always_comb begin
    nxt = '0;
    nxt[A]     = reg_a;
    nxt[L]     = reg_l;
    nxt[Q]     = reg_q;
    nxt[CYR]   = reg_cyr;
    nxt[SR]    = reg_sr;
    nxt[CYL]   = reg_cyl;
    nxt[SL]    = reg_sl;
    nxt[TIME1] = reg_time1;
    nxt[TIME2] = reg_time2;

    // Later port overrides on a shared target
    if (wr1.en) begin
      nxt[wr1.sel] = wr1_val;
    end
    if (wr2.en) begin
      nxt[wr2.sel] = wr2_val;
    end

    // Bank views and the constant always rebuilt
    nxt[EB]   = {3'd0, bank_next.eb, 9'd0};
    nxt[FB]   = {bank_next.fb, 12'd0};
    nxt[BB]   = {bank_next.fb, bank_next.eb, 9'd0};
    nxt[ZERO] = '0;
  end

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      reg_a     <= '0;
      reg_l     <= '0;
      reg_q     <= '0;
      reg_cyr   <= '0;
      reg_sr    <= '0;
      reg_cyl   <= '0;
      reg_sl    <= '0;
      reg_time1 <= '0;
      reg_time2 <= '0;
      bank_q    <= '0;
    end else begin
      reg_a     <= nxt[A];
      reg_l     <= nxt[L];
      reg_q     <= nxt[Q];
      reg_cyr   <= nxt[CYR];
      reg_sr    <= nxt[SR];
      reg_cyl   <= nxt[CYL];
      reg_sl    <= nxt[SL];
      reg_time1 <= nxt[TIME1];
      reg_time2 <= nxt[TIME2];
      bank_q    <= bank_next;
    end
  end

  // Reads see pending writes
  assign rs1_data = nxt[rs1_sel];
  assign rs2_data = nxt[rs2_sel];

  // Translation only sees stored banks
  assign banks = bank_q;

endmodule

// ==== src/erasable_addr_map.sv ====
// Software address to erasable-memory address translation through the EB bank
`timescale 1ns/1ns

module erasable_addr_map (
  input  agc_pkg::soft_addr_t addr,
  input  agc_pkg::bank_t      eb,
  output agc_pkg::ram_addr_t  ram_addr
);

  import agc_pkg::*;

  ram_addr_t bank_offset;
  ram_addr_t banked_addr;
  logic      is_unbanked;

  always_comb begin
    // Top EB bit selects the upper half of RAM outright
    if (eb[2]) begin
      bank_offset = 11'o2000;
    end else begin
      bank_offset = ram_addr_t'(eb[1:0]) * ERASABLE_BANK_SIZE;
    end

    is_unbanked = (addr < ERASABLE_BANKED_BASE);

    // Wraps at 11 bits
    banked_addr = addr[10:0] + bank_offset;

    ram_addr = is_unbanked ? addr[10:0] : banked_addr;
  end

endmodule

// ==== src/fixed_addr_map.sv ====
// Software address to fixed-memory address translation through the FB bank
`timescale 1ns/1ns

module fixed_addr_map (
  input  agc_pkg::soft_addr_t addr,
  input  agc_pkg::bank_t      fb,
  output agc_pkg::rom_addr_t  rom_addr
);

  import agc_pkg::*;

  rom_addr_t bank_offset;
  rom_addr_t fixed_fixed_addr;
  rom_addr_t banked_addr;

  always_comb begin
    // Offset of bank fb in ROM
    case (fb)
      3'd0:    bank_offset = 14'o00000;
      3'd1:    bank_offset = 14'o02000;
      3'd2:    bank_offset = 14'o04000;
      3'd3:    bank_offset = 14'o06000;
      3'd4:    bank_offset = 14'o10000;
      3'd5:    bank_offset = 14'o12000;
      3'd6:    bank_offset = 14'o14000;
      default: bank_offset = 14'o16000;
    endcase

    // Fixed-fixed lands at the bottom of ROM
    fixed_fixed_addr = rom_addr_t'(addr) - rom_addr_t'(FIXED_FIXED_BASE);

    // Banked window wraps at 14 bits
    banked_addr = rom_addr_t'(addr) + FIXED_BANK_SIZE + bank_offset;

    rom_addr = (addr >= FIXED_FIXED_BASE) ? fixed_fixed_addr : banked_addr;
  end

endmodule

// ==== verification/agc_reg_addr_tb.sv ====
// Testbench with clock, reset, random stimulus, reference model, output checks and watchdog
`timescale 1ns/1ns

module agc_reg_addr_tb;

  import agc_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int N_IDLE       = 16;
  localparam int N_PLAIN      = 60;
  localparam int N_EDIT       = 40;
  localparam int N_BANK       = 40;
  localparam int N_XLATE      = 60;
  localparam int N_GATE       = 40;
  localparam int TOTAL_CYCLES = RESET_CYCLES + N_IDLE + N_PLAIN + N_EDIT + N_BANK
                                + N_XLATE + N_GATE + 2;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 50) * CLK_PERIOD;
  localparam logic [31:0] RAND_SEED = 32'ha112_9870;

  logic       clk;
  logic       rst_l;
  reg_write_t wr1;
  reg_write_t wr2;
  reg_sel_t   rs1_sel;
  reg_sel_t   rs2_sel;
  soft_addr_t addr_pc;
  soft_addr_t addr_r;
  soft_addr_t addr_w;
  logic       mem_write_en;
  word_t      rs1_data;
  word_t      rs2_data;
  rom_addr_t  rom_addr_pc;
  rom_addr_t  rom_addr_r;
  ram_addr_t  ram_addr_r;
  ram_addr_t  ram_addr_w;
  logic       ram_write_en;

  string test_name;
  int    error_count;

  // Reference model state with the banks kept apart from the word registers
  word_t m_regs [16];
  bank_t m_eb;
  bank_t m_fb;

  agc_reg_addr_top i_agc_reg_addr_top (
    .clk          (clk),
    .rst_l        (rst_l),
    .wr1          (wr1),
    .wr2          (wr2),
    .rs1_sel      (rs1_sel),
    .rs2_sel      (rs2_sel),
    .addr_pc      (addr_pc),
    .addr_r       (addr_r),
    .addr_w       (addr_w),
    .mem_write_en (mem_write_en),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .rom_addr_pc  (rom_addr_pc),
    .rom_addr_r   (rom_addr_r),
    .ram_addr_r   (ram_addr_r),
    .ram_addr_w   (ram_addr_w),
    .ram_write_en (ram_write_en)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Word as an editing register would keep it
  function automatic word_t edit_value(reg_sel_t sel, word_t d);
    case (sel)
      CYR:     return (d >> 1) | (d << 14);
      SR:      return word_t'($signed(d) >>> 1);
      CYL:     return (d << 1) | (d >> 14);
      SL:      return d << 1;
      default: return d;
    endcase
  endfunction

  // Effect of one write port on the selector being looked at
  function automatic void apply_write(input reg_write_t p, input reg_sel_t sel,
                                      inout word_t v, inout bank_t eb, inout bank_t fb);
    if (p.en) begin
      case (p.sel)
        EB: eb = p.data[11:9];
        FB: fb = p.data[14:12];
        BB: begin
          eb = p.data[11:9];
          fb = p.data[14:12];
        end
        ZERO: ;
        default: begin
          if (p.sel == sel) begin
            v = edit_value(sel, p.data);
          end
        end
      endcase
    end
  endfunction

  // Value a selector holds once the coming edge has taken the current writes
  function automatic word_t after_edge(reg_sel_t sel);
    word_t v;
    bank_t eb;
    bank_t fb;
    v = m_regs[sel];
    eb = m_eb;
    fb = m_fb;
    // Port 2 applied last so it wins
    apply_write(wr1, sel, v, eb, fb);
    apply_write(wr2, sel, v, eb, fb);
    case (sel)
      EB:      v = {3'd0, eb, 9'd0};
      FB:      v = {fb, 12'd0};
      BB:      v = {fb, eb, 9'd0};
      ZERO:    v = '0;
      default: ;
    endcase
    return v;
  endfunction

  function automatic rom_addr_t expected_rom_addr(soft_addr_t addr, bank_t fb);
    if (addr >= FIXED_FIXED_BASE) begin
      return rom_addr_t'(addr - FIXED_FIXED_BASE);
    end
    return rom_addr_t'(addr) + FIXED_BANK_SIZE + rom_addr_t'(fb) * FIXED_BANK_SIZE;
  endfunction

  function automatic ram_addr_t expected_ram_addr(soft_addr_t addr, bank_t eb);
    ram_addr_t off;
    if (addr < ERASABLE_BANKED_BASE) begin
      return addr[10:0];
    end
    if (eb[2]) begin
      off = 11'o2000;
    end else begin
      off = ram_addr_t'(eb[1:0]) * ERASABLE_BANK_SIZE;
    end
    return addr[10:0] + off;
  endfunction

  task automatic model_commit();
    word_t      next_regs [16];
    word_t      bb_word;
    logic [3:0] s;
    for (s = 4'd0; s < 4'd13; s++) begin
      next_regs[s] = after_edge(reg_sel_t'(s));
    end
    bb_word = after_edge(BB);
    for (s = 4'd0; s < 4'd13; s++) begin
      m_regs[s] = next_regs[s];
    end
    m_fb = bb_word[14:12];
    m_eb = bb_word[11:9];
  endtask

  task automatic model_reset();
    logic [4:0] s;
    for (s = 5'd0; s < 5'd16; s++) begin
      m_regs[s[3:0]] = '0;
    end
    m_eb = '0;
    m_fb = '0;
  endtask

  always @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      model_reset();
    end else begin
      model_commit();
    end
  end

  task automatic report_mismatch(string what, logic [14:0] expected, logic [14:0] actual);
    error_count++;
    $display("[ERROR] %s: %s expected %0o actual %0o", test_name, what, expected, actual);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_outputs();
    word_t     exp_word;
    rom_addr_t exp_rom;
    ram_addr_t exp_ram;
    logic      exp_we;
    exp_word = after_edge(rs1_sel);
    assert (rs1_data === exp_word) else report_mismatch("rs1_data", exp_word, rs1_data);
    exp_word = after_edge(rs2_sel);
    assert (rs2_data === exp_word) else report_mismatch("rs2_data", exp_word, rs2_data);

    exp_rom = expected_rom_addr(addr_pc, m_fb);
    assert (rom_addr_pc === exp_rom)
      else report_mismatch("rom_addr_pc", 15'(exp_rom), 15'(rom_addr_pc));

    // Read side parks the unused memory on its idle address
    if (addr_r < ERASABLE_TOP) begin
      exp_rom = ROM_IDLE_ADDR;
      exp_ram = expected_ram_addr(addr_r, m_eb);
    end else begin
      exp_rom = expected_rom_addr(addr_r, m_fb);
      exp_ram = '0;
    end
    assert (rom_addr_r === exp_rom)
      else report_mismatch("rom_addr_r", 15'(exp_rom), 15'(rom_addr_r));
    assert (ram_addr_r === exp_ram)
      else report_mismatch("ram_addr_r", 15'(exp_ram), 15'(ram_addr_r));

    exp_ram = expected_ram_addr(addr_w, m_eb);
    assert (ram_addr_w === exp_ram)
      else report_mismatch("ram_addr_w", 15'(exp_ram), 15'(ram_addr_w));
    exp_we = mem_write_en && (addr_w < ERASABLE_TOP);
    assert (ram_write_en === exp_we)
      else report_mismatch("ram_write_en", 15'(exp_we), 15'(ram_write_en));
  endtask

  // Outputs settle well before the next edge
  always begin
    @(posedge clk);
    #(CLK_PERIOD - 1);
    check_outputs();
  end

  function automatic reg_write_t make_write(logic en, reg_sel_t sel, word_t data);
    reg_write_t w;
    w.en = en;
    w.sel = sel;
    w.data = data;
    return w;
  endfunction

  function automatic word_t random_word();
    return word_t'($urandom());
  endfunction

  // Picks one of the four memory regions, then an address inside it
  function automatic soft_addr_t region_addr();
    case ($urandom_range(0, 3))
      0:       return soft_addr_t'($urandom_range(0, 'o1377));
      1:       return soft_addr_t'($urandom_range('o1400, 'o1777));
      2:       return soft_addr_t'($urandom_range('o2000, 'o3777));
      default: return soft_addr_t'($urandom_range('o4000, 'o7777));
    endcase
  endfunction

  function automatic reg_sel_t plain_sel();
    case ($urandom_range(0, 4))
      0:       return A;
      1:       return L;
      2:       return Q;
      3:       return TIME1;
      default: return TIME2;
    endcase
  endfunction

  function automatic reg_sel_t edit_sel();
    case ($urandom_range(0, 3))
      0:       return CYR;
      1:       return SR;
      2:       return CYL;
      default: return SL;
    endcase
  endfunction

  function automatic reg_sel_t bank_sel();
    case ($urandom_range(0, 3))
      0:       return EB;
      1:       return FB;
      2:       return BB;
      default: return ZERO;
    endcase
  endfunction

  function automatic reg_sel_t any_sel();
    return reg_sel_t'(4'($urandom_range(0, 12)));
  endfunction

  task automatic random_addresses();
    addr_pc = region_addr();
    addr_r = region_addr();
    addr_w = region_addr();
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  initial begin
    int       i;
    reg_sel_t sel;
    reg_sel_t last_sel;
    word_t    d;
    void'($urandom(RAND_SEED));
    error_count = 0;
    test_name = "reset";
    rst_l = 1'b0;
    wr1 = '0;
    wr2 = '0;
    rs1_sel = A;
    rs2_sel = A;
    addr_pc = '0;
    addr_r = '0;
    addr_w = '0;
    mem_write_en = 1'b0;
    repeat (RESET_CYCLES) next_cycle();
    rst_l = 1'b1;

    // Every selector reads zero, bank 0 in use, no erasable write
    test_name = "after_reset";
    for (i = 0; i < N_IDLE; i++) begin
      rs1_sel = reg_sel_t'(4'(i % 13));
      rs2_sel = reg_sel_t'(4'(12 - (i % 13)));
      random_addresses();
      next_cycle();
    end

    test_name = "plain_write";
    last_sel = A;
    for (i = 0; i < N_PLAIN; i++) begin
      sel = plain_sel();
      d = random_word();
      case ($urandom_range(0, 3))
        0: begin
          wr1 = make_write(1'b1, sel, d);
          wr2 = '0;
        end
        1: begin
          wr1 = '0;
          wr2 = make_write(1'b1, sel, d);
        end
        // Same target on both ports
        2: begin
          wr1 = make_write(1'b1, sel, random_word());
          wr2 = make_write(1'b1, sel, d);
        end
        default: begin
          wr1 = make_write(1'b1, plain_sel(), random_word());
          wr2 = make_write(1'b1, sel, d);
        end
      endcase
      rs1_sel = last_sel;
      rs2_sel = plain_sel();
      last_sel = sel;
      next_cycle();
    end

    // rs1 looks at the register being written, rs2 at the one before
    test_name = "edit_write";
    for (i = 0; i < N_EDIT; i++) begin
      sel = edit_sel();
      d = random_word();
      if ($urandom_range(0, 1) == 0) begin
        wr1 = make_write(1'b1, sel, d);
        wr2 = '0;
      end else begin
        wr1 = '0;
        wr2 = make_write(1'b1, sel, d);
      end
      rs1_sel = sel;
      rs2_sel = last_sel;
      last_sel = sel;
      next_cycle();
    end

    test_name = "bank_write";
    for (i = 0; i < N_BANK; i++) begin
      wr1 = make_write(1'($urandom_range(0, 1)), bank_sel(), random_word());
      wr2 = make_write(1'($urandom_range(0, 1)), bank_sel(), random_word());
      rs1_sel = bank_sel();
      rs2_sel = bank_sel();
      random_addresses();
      next_cycle();
    end

    test_name = "translate";
    wr1 = '0;
    for (i = 0; i < N_XLATE; i++) begin
      if (i % 4 == 0) begin
        wr2 = make_write(1'b1, BB, random_word());
      end else begin
        wr2 = '0;
      end
      rs1_sel = BB;
      rs2_sel = any_sel();
      mem_write_en = 1'($urandom_range(0, 1));
      random_addresses();
      next_cycle();
    end

    test_name = "write_gate";
    wr2 = '0;
    for (i = 0; i < N_GATE; i++) begin
      if (i % 8 == 0) begin
        wr1 = make_write(1'b1, EB, random_word());
      end else begin
        wr1 = '0;
      end
      mem_write_en = 1'($urandom_range(0, 1));
      random_addresses();
      next_cycle();
    end

    wr1 = '0;
    wr2 = '0;
    mem_write_en = 1'b0;
    repeat (2) next_cycle();
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run length bound from the cycle counts above
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Finished with errors");
    $fatal(1, "Watchdog expired");
  end

endmodule
